/* logic/video_consts.svh */
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// line and frame timing in clk_reg cycles and lines
`define H_TOTAL     456
`define V_TOTAL     154
`define V_VISIBLE   144

// mode 2 covers the first 80 cycles of a visible line
`define OAM_LEN     80

// mode 3 has a fixed length and hblank starts here
`define MODE3_END   256

// visible pixels per line
`define LCD_WIDTH   160

// register addresses as the low byte of the ff40 block
`define REG_LCDC    8'h40
`define REG_STAT    8'h41
`define REG_SCY     8'h42
`define REG_SCX     8'h43
`define REG_LY      8'h44
`define REG_LYC     8'h45
`define REG_BGP     8'h47

// reset palette maps colour 0 to the lightest shade and the rest to the darkest
`define BGP_RESET   8'hfc

`endif

/* logic/video_pkg.sv */
`default_nettype none

package video_pkg;

	// cycle within a line, 0 to 455
	typedef logic [8:0] h_count_t;
	// line number, 0 to 153
	typedef logic [7:0] line_t;
	typedef logic [12:0] vram_addr_t;
	// colour index before the palette, shade after it
	typedef logic [1:0] shade_t;

	typedef enum logic [1:0] {
		MODE_HBLANK = 2'd0,
		MODE_VBLANK = 2'd1,
		MODE_OAM    = 2'd2,
		MODE_DRAW   = 2'd3
	} lcd_mode_t;

	// cpu side of the register file, wr is a single cycle strobe
	typedef struct packed {
		logic [7:0] addr;
		logic       wr;
		logic [7:0] di;
	} cpu_bus_t;

	typedef struct packed {
		h_count_t h;
		line_t    ly;
	} lcd_pos_t;

	// register fields the background fetcher works from
	typedef struct packed {
		logic       bg_map_sel;
		logic       tile_data_sel;
		logic       bg_ena;
		logic [7:0] scx;
		logic [7:0] scy;
		logic [7:0] bgp;
	} bg_ctrl_t;

	typedef struct packed {
		logic   valid;
		shade_t shade;
	} pixel_t;

endpackage

`default_nettype wire

/* logic/lcd_timing.sv */
`default_nettype none

`include "video_consts.svh"

module lcd_timing (
	input  logic                 clk_reg,
	input  logic                 reset,
	input  logic                 lcd_on,
	output video_pkg::lcd_pos_t  pos,
	output video_pkg::lcd_mode_t mode
);
	import video_pkg::*;

	lcd_pos_t  pos_next;
	lcd_mode_t mode_next;

	// next position, parked at the origin while the lcd is off
	always_comb begin
		pos_next = '0;
		if (lcd_on) begin
			if (pos.h == h_count_t'(`H_TOTAL - 1)) begin
				// end of line, ly wraps after the last vblank line
				pos_next.h = '0;
				if (pos.ly == line_t'(`V_TOTAL - 1))
					pos_next.ly = '0;
				else
					pos_next.ly = pos.ly + 8'd1;
			end else begin
				pos_next.h  = pos.h + 9'd1;
				pos_next.ly = pos.ly;
			end
		end
	end

	// mode is decoded from the next position so it lines up with pos
	always_comb begin
		if (!lcd_on)
			mode_next = MODE_HBLANK;
		else if (pos_next.ly >= line_t'(`V_VISIBLE))
			mode_next = MODE_VBLANK;
		else if (pos_next.h < h_count_t'(`OAM_LEN))
			mode_next = MODE_OAM;
		else if (pos_next.h < h_count_t'(`MODE3_END))
			mode_next = MODE_DRAW;
		else
			mode_next = MODE_HBLANK;
	end

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			pos  <= '0;
			mode <= MODE_HBLANK;
		end else begin
			pos  <= pos_next;
			mode <= mode_next;
		end
	end

	// both counters stay inside one frame
	a_pos_range: assert property (@(posedge clk_reg) disable iff (reset)
		pos.h < h_count_t'(`H_TOTAL) && pos.ly < line_t'(`V_TOTAL));

endmodule

`default_nettype wire

/* logic/video_regs.sv */
`default_nettype none

`include "video_consts.svh"

module video_regs (
	input  logic                 clk_reg,
	input  logic                 reset,
	input  video_pkg::cpu_bus_t  cpu,
	output logic [7:0]           cpu_do,
	input  video_pkg::lcd_pos_t  pos,
	input  video_pkg::lcd_mode_t mode,
	output logic                 lcd_on,
	output video_pkg::bg_ctrl_t  bg_ctrl,
	output logic                 irq,
	output logic                 vblank_irq
);
	import video_pkg::*;

	logic [7:0] lcdc;
	// stat interrupt enables, bits 6 to 3 of STAT
	logic [3:0] stat_en;
	logic [7:0] scy;
	logic [7:0] scx;
	logic [7:0] lyc;
	logic [7:0] bgp;
	logic       lyc_changed;
	logic       lyc_match;
	logic       visible;
	logic       line_start;
	logic       vblank_start;
	logic       hblank_start;

	// --------------------------------------------------------------------------
	// register writes
	// --------------------------------------------------------------------------

	always_ff @(posedge clk_reg) begin
		if (reset) begin
			// lcdc clears to zero so the display comes up off
			lcdc        <= 8'h00;
			stat_en     <= 4'h0;
			scy         <= 8'h00;
			scx         <= 8'h00;
			lyc         <= 8'h00;
			bgp         <= `BGP_RESET;
			lyc_changed <= 1'b0;
		end else begin
			lyc_changed <= 1'b0;
			if (cpu.wr) begin
				case (cpu.addr)
					`REG_LCDC: lcdc <= cpu.di;
					`REG_STAT: stat_en <= cpu.di[6:3];
					`REG_SCY:  scy <= cpu.di;
					`REG_SCX:  scx <= cpu.di;
					`REG_LYC: begin
						lyc         <= cpu.di;
						lyc_changed <= 1'b1;
					end
					`REG_BGP:  bgp <= cpu.di;
					// LY and unmapped addresses are read only
					default: ;
				endcase
			end
		end
	end

	// --------------------------------------------------------------------------
	// read mux
	// --------------------------------------------------------------------------

	always_comb begin
		case (cpu.addr)
			`REG_LCDC: cpu_do = lcdc;
			`REG_STAT: cpu_do = {1'b1, stat_en, lyc_match, mode};
			`REG_SCY:  cpu_do = scy;
			`REG_SCX:  cpu_do = scx;
			`REG_LY:   cpu_do = pos.ly;
			`REG_LYC:  cpu_do = lyc;
			`REG_BGP:  cpu_do = bgp;
			default:   cpu_do = 8'hff;
		endcase
	end

	// lcdc bits 6, 5, 2 and 1 only read back
	assign lcd_on  = lcdc[7];
	assign bg_ctrl = '{
		bg_map_sel:    lcdc[3],
		tile_data_sel: lcdc[4],
		bg_ena:        lcdc[0],
		scx:           scx,
		scy:           scy,
		bgp:           bgp
	};

	// --------------------------------------------------------------------------
	// interrupts
	// --------------------------------------------------------------------------

	assign lyc_match    = (pos.ly == lyc);
	assign visible      = (pos.ly < line_t'(`V_VISIBLE));
	assign line_start   = (pos.h == '0);
	assign vblank_start = line_start && (pos.ly == line_t'(`V_VISIBLE));
	assign hblank_start = visible && (pos.h == h_count_t'(`MODE3_END));

	// strobes land one cycle after the triggering position
	// pos sits at 0,0 while off so everything is gated by lcd_on
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			irq        <= 1'b0;
			vblank_irq <= 1'b0;
		end else begin
			irq <= lcd_on && (
				(stat_en[3] && lyc_match && (line_start || lyc_changed)) ||
				(stat_en[2] && line_start && visible) ||
				(stat_en[1] && vblank_start) ||
				(stat_en[0] && hblank_start));
			vblank_irq <= lcd_on && vblank_start;
		end
	end

	// the vblank strobe only shows up on the first vblank line of the timing block
	a_vblank_line: assert property (@(posedge clk_reg) disable iff (reset)
		vblank_irq |-> pos.ly == line_t'(`V_VISIBLE));

endmodule

`default_nettype wire

/* logic/bg_fetch.sv */
`default_nettype none

`include "video_consts.svh"

module bg_fetch (
	input  logic                  clk_reg,
	input  logic                  reset,
	input  video_pkg::lcd_pos_t   pos,
	input  video_pkg::lcd_mode_t  mode,
	input  video_pkg::bg_ctrl_t   bg_ctrl,
	output logic                  vram_rd,
	output video_pkg::vram_addr_t vram_addr,
	input  logic [7:0]            vram_data,
	output video_pkg::pixel_t     pixel
);
	import video_pkg::*;

	// register values frozen for the line
	bg_ctrl_t   ctrl_r;
	// cycle count from the start of mode 3
	h_count_t   h_rel;
	logic [2:0] phase;
	logic [4:0] tile_col;
	line_t      bg_line;
	logic       fetch_win;
	logic       shift_win;
	logic       tile_a12;
	logic [7:0] tile_num;
	logic [7:0] data_lo;
	logic [7:0] data_hi;
	logic [7:0] shift_lo;
	logic [7:0] shift_hi;
	logic [2:0] skip_cnt;
	logic [7:0] out_cnt;
	shade_t     color;
	logic       pix_valid;
	shade_t     pix_shade;

	// --------------------------------------------------------------------------
	// fetch sequencer and vram addressing
	// --------------------------------------------------------------------------

	assign h_rel    = pos.h - h_count_t'(`OAM_LEN);
	assign phase    = h_rel[2:0];
	// tile column wraps at 32 across the map
	assign tile_col = ctrl_r.scx[7:3] + h_rel[7:3];
	assign bg_line  = pos.ly + ctrl_r.scy;

	// 21 tiles, one more than the screen width for the fine scroll
	assign fetch_win = (mode == MODE_DRAW) && (h_rel < h_count_t'(`LCD_WIDTH + 8));
	// pixels leave the shifter from the second tile group on
	assign shift_win = (mode == MODE_DRAW) && (pos.h >= h_count_t'(`OAM_LEN + 8));

	// signed tile numbers use the 8800 block
	assign tile_a12 = !ctrl_r.tile_data_sel ? ~tile_num[7] : 1'b0;

	// map at phase 0, data low at 2, data high at 4
	assign vram_rd = fetch_win && (phase == 3'd0 || phase == 3'd2 || phase == 3'd4);

	// phase bit 2 picks the high byte of the tile row
	assign vram_addr = (phase == 3'd0) ?
		{2'b11, ctrl_r.bg_map_sel, bg_line[7:3], tile_col} :
		{tile_a12, tile_num, bg_line[2:0], phase[2]};

	// --------------------------------------------------------------------------
	// capture, shift registers and palette
	// --------------------------------------------------------------------------

	assign color = {shift_hi[7], shift_lo[7]};

	always_ff @(posedge clk_reg) begin
		// latch one cycle before mode 3
		if (pos.h == h_count_t'(`OAM_LEN - 1))
			ctrl_r <= bg_ctrl;

		// vram answers one cycle after each read
		if (fetch_win) begin
			case (phase)
				3'd1: tile_num <= vram_data;
				3'd3: data_lo <= vram_data;
				3'd5: data_hi <= vram_data;
				default: ;
			endcase
		end

		if (fetch_win && phase == 3'd7) begin
			shift_lo <= data_lo;
			shift_hi <= data_hi;
		end else begin
			shift_lo <= {shift_lo[6:0], 1'b0};
			shift_hi <= {shift_hi[6:0], 1'b0};
		end

		// shade is bgp[2c+1:2c], white when the background is off
		if (ctrl_r.bg_ena)
			pix_shade <= ctrl_r.bgp[{color, 1'b0} +: 2];
		else
			pix_shade <= 2'b00;
	end

	// fine scroll discard, then exactly one line of strobes
	always_ff @(posedge clk_reg) begin
		if (reset) begin
			skip_cnt  <= '0;
			out_cnt   <= '0;
			pix_valid <= 1'b0;
		end else begin
			pix_valid <= 1'b0;
			if (pos.h == h_count_t'(`OAM_LEN - 1)) begin
				skip_cnt <= bg_ctrl.scx[2:0];
				out_cnt  <= '0;
			end else if (shift_win) begin
				if (skip_cnt != 3'd0)
					skip_cnt <= skip_cnt - 3'd1;
				else if (out_cnt != 8'(`LCD_WIDTH)) begin
					out_cnt   <= out_cnt + 8'd1;
					pix_valid <= 1'b1;
				end
			end
		end
	end

	assign pixel = '{valid: pix_valid, shade: pix_shade};

	// no fetches outside the visible lines of the frame
	a_no_vblank_rd: assert property (@(posedge clk_reg) disable iff (reset)
		vram_rd |-> pos.ly < line_t'(`V_VISIBLE));

	// a visible line has sent its full width by the first hblank cycle
	a_line_width: assert property (@(posedge clk_reg) disable iff (reset)
		(mode == MODE_HBLANK && pos.h == h_count_t'(`MODE3_END) &&
			pos.ly < line_t'(`V_VISIBLE)) |-> out_cnt == 8'(`LCD_WIDTH));

endmodule

`default_nettype wire

/* logic/video.sv */
`default_nettype none

module video (
	input  logic                  clk_reg,
	input  logic                  reset,
	input  video_pkg::cpu_bus_t   cpu,
	output logic [7:0]            cpu_do,
	output logic                  vram_rd,
	output video_pkg::vram_addr_t vram_addr,
	input  logic [7:0]            vram_data,
	output video_pkg::pixel_t     pixel,
	output logic                  irq,
	output logic                  vblank_irq,
	output logic                  lcd_on
);
	import video_pkg::*;

	// line position and mode from the timing block
	lcd_pos_t  pos;
	lcd_mode_t mode;
	// background settings from the register file
	bg_ctrl_t  bg_ctrl;

	lcd_timing timing_i (
		.clk_reg (clk_reg),
		.reset   (reset),
		.lcd_on  (lcd_on),
		.pos     (pos),
		.mode    (mode)
	);

	video_regs regs_i (
		.clk_reg    (clk_reg),
		.reset      (reset),
		.cpu        (cpu),
		.cpu_do     (cpu_do),
		.pos        (pos),
		.mode       (mode),
		.lcd_on     (lcd_on),
		.bg_ctrl    (bg_ctrl),
		.irq        (irq),
		.vblank_irq (vblank_irq)
	);

	bg_fetch fetch_i (
		.clk_reg   (clk_reg),
		.reset     (reset),
		.pos       (pos),
		.mode      (mode),
		.bg_ctrl   (bg_ctrl),
		.vram_rd   (vram_rd),
		.vram_addr (vram_addr),
		.vram_data (vram_data),
		.pixel     (pixel)
	);

endmodule

`default_nettype wire

/* testbench/video_checker.sv */
`default_nettype none

`include "video_consts.svh"

module video_checker (
	input logic                clk_reg,
	input logic                reset,
	input video_pkg::cpu_bus_t cpu,
	input logic                vram_rd,
	input video_pkg::pixel_t   pixel,
	input logic                irq,
	input logic                vblank_irq,
	input logic                lcd_on
);
	import video_pkg::*;

	// shadow registers from the cpu writes
	logic [7:0] sh_lcdc = 8'h00;
	logic [7:0] sh_scx = 8'h00;
	logic [7:0] sh_scy = 8'h00;
	logic [7:0] sh_bgp = `BGP_RESET;
	// modelled position of the dut
	int         m_h = 0;
	int         m_ly = 0;
	int         line_pix = 0;
	int         irq_cnt = 0;
	int         frame_irqs = 0;
	int         vbl_gap = 0;
	int         off_cnt = 0;
	int         mismatches = 0;
	int         failures = 0;
	logic       synced = 1'b0;
	logic       on_prev = 1'b0;
	logic       have_vbl = 1'b0;

	function automatic logic [7:0] vram_byte(input logic [12:0] a);
		return a[7:0] ^ 8'(37 * int'(a[12:8]));
	endfunction

	// expected shade of screen pixel x on line y
	function automatic logic [1:0] ref_shade(input int x, input int y);
		int         bx;
		int         by;
		int         map_addr;
		int         tile;
		int         row_addr;
		int         bitn;
		int         c;
		logic [7:0] lo;
		logic [7:0] hi;
		bx = (int'(sh_scx) + x) % 256;
		by = (int'(sh_scy) + y) % 256;
		map_addr = 'h1800 + (sh_lcdc[3] ? 'h400 : 0) + (by / 8) * 32 + bx / 8;
		tile = int'(vram_byte(13'(map_addr)));
		// signed tiles 0 to 127 sit at 1000 and tiles 128 and up share the 0800 block
		if (sh_lcdc[4] || tile >= 128)
			row_addr = tile * 16 + (by % 8) * 2;
		else
			row_addr = 'h1000 + tile * 16 + (by % 8) * 2;
		lo = vram_byte(13'(row_addr));
		hi = vram_byte(13'(row_addr + 1));
		bitn = 7 - bx % 8;
		c = int'({hi[bitn], lo[bitn]});
		if (!sh_lcdc[0])
			return 2'b00;
		return sh_bgp[2 * c +: 2];
	endfunction

	task automatic check_value(input string name, input int exp, input int act);
		if (exp != act) begin
			mismatches = mismatches + 1;
			$display("mismatch %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic report(input string msg);
		failures = failures + 1;
		$display("%s (line %0d, cycle %0d)", msg, m_ly, m_h);
	endtask

	always @(posedge clk_reg) begin
		if (!reset && cpu.wr) begin
			case (cpu.addr)
				`REG_LCDC: sh_lcdc <= cpu.di;
				`REG_SCX:  sh_scx <= cpu.di;
				`REG_SCY:  sh_scy <= cpu.di;
				`REG_BGP:  sh_bgp <= cpu.di;
				default: ;
			endcase
		end
	end

	always @(negedge clk_reg) begin
		if (reset) begin
			synced  = 1'b0;
			on_prev = 1'b0;
		end else begin
			// lcd_on follows LCDC bit 7 from the cycle after the write
			check_value("lcd_on", int'(sh_lcdc[7]), int'(lcd_on));

			// --------------------------------------------------------------------
			// position model with its origin on the first cycle with the lcd on
			// --------------------------------------------------------------------
			if (lcd_on && !on_prev) begin
				m_h      = 0;
				m_ly     = 0;
				line_pix = 0;
				synced   = 1'b1;
				have_vbl = 1'b0;
			end else if (lcd_on && synced) begin
				vbl_gap = vbl_gap + 1;
				if (m_h == `H_TOTAL - 1) begin
					if (m_ly < `V_VISIBLE && line_pix != `LCD_WIDTH)
						check_value($sformatf("pixels on line %0d", m_ly), `LCD_WIDTH,
							line_pix);
					line_pix = 0;
					m_h      = 0;
					m_ly     = (m_ly == `V_TOTAL - 1) ? 0 : m_ly + 1;
				end else begin
					m_h = m_h + 1;
				end
			end

			// pipeline drains one cycle after the lcd goes off
			off_cnt = lcd_on ? 0 : off_cnt + 1;
			if (off_cnt >= 2 && (pixel.valid || irq || vblank_irq || vram_rd))
				report("pixel, interrupt or vram read while the lcd is off");

			if (lcd_on && synced) begin
				if (vram_rd && m_ly >= `V_VISIBLE)
					report("vram read during vblank");
				if (pixel.valid) begin
					if (m_ly >= `V_VISIBLE)
						report("pixel strobe during vblank");
					else if (line_pix >= `LCD_WIDTH)
						report("more than 160 pixels on a line");
					else
						check_value($sformatf("pixel x%0d y%0d", line_pix, m_ly),
							int'(ref_shade(line_pix, m_ly)), int'(pixel.shade));
					line_pix = line_pix + 1;
				end
			end

			// the vblank strobe marks the frame boundary at h=1 of line 144
			if (vblank_irq) begin
				if (!(lcd_on && m_ly == `V_VISIBLE && m_h == 1))
					report("vblank strobe at the wrong position");
				if (have_vbl)
					check_value("vblank period", `H_TOTAL * `V_TOTAL, vbl_gap);
				have_vbl   = 1'b1;
				vbl_gap    = 0;
				frame_irqs = irq_cnt + int'(irq);
				irq_cnt    = 0;
			end else begin
				irq_cnt = irq_cnt + int'(irq);
			end

			if (!lcd_on)
				have_vbl = 1'b0;
			on_prev = lcd_on;
		end
	end

endmodule

`default_nettype wire

/* testbench/video_tb.sv */
`default_nettype none

`include "video_consts.svh"

module video_tb;
	import video_pkg::*;

	logic       clk_reg = 1'b0;
	logic       reset;
	cpu_bus_t   cpu;
	logic [7:0] cpu_do;
	logic       vram_rd;
	vram_addr_t vram_addr;
	logic [7:0] vram_data = 8'h00;
	pixel_t     pixel;
	logic       irq;
	logic       vblank_irq;
	logic       lcd_on;

	integer     seed;
	int         cycles = 0;
	int         reg_errors = 0;
	logic [7:0] sh_lyc;
	logic [7:0] sh_stat;
	logic [7:0] rd;
	// stat irqs per frame for sources lyc, oam, vblank, hblank
	int         exp_irqs [4] = '{1, 144, 1, 144};
	logic [7:0] unmapped [4] = '{8'h46, 8'h48, 8'h00, 8'hff};

	video dut_i (
		.clk_reg    (clk_reg),
		.reset      (reset),
		.cpu        (cpu),
		.cpu_do     (cpu_do),
		.vram_rd    (vram_rd),
		.vram_addr  (vram_addr),
		.vram_data  (vram_data),
		.pixel      (pixel),
		.irq        (irq),
		.vblank_irq (vblank_irq),
		.lcd_on     (lcd_on)
	);

	video_checker chk_i (
		.clk_reg    (clk_reg),
		.reset      (reset),
		.cpu        (cpu),
		.vram_rd    (vram_rd),
		.pixel      (pixel),
		.irq        (irq),
		.vblank_irq (vblank_irq),
		.lcd_on     (lcd_on)
	);

	always #10 clk_reg = ~clk_reg;

	// vram contents are the low address byte xor 37 times the upper five bits
	function automatic logic [7:0] vram_byte(input logic [12:0] a);
		return a[7:0] ^ 8'(37 * int'(a[12:8]));
	endfunction

	// synchronous vram returns data one cycle after a read
	always @(posedge clk_reg)
		if (vram_rd)
			vram_data <= vram_byte(vram_addr);

	// six frames of 70224 cycles fit well under this limit
	always @(posedge clk_reg) begin
		cycles = cycles + 1;
		if (cycles >= 500000) begin
			$display("timeout after %0d cycles, test did not finish", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic write_reg(input logic [7:0] a, input logic [7:0] d);
		@(negedge clk_reg);
		cpu.addr = a;
		cpu.wr   = 1'b1;
		cpu.di   = d;
		@(negedge clk_reg);
		cpu.wr = 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] a, output logic [7:0] d);
		@(negedge clk_reg);
		cpu.addr = a;
		cpu.wr   = 1'b0;
		#5;
		d = cpu_do;
	endtask

	task automatic check_reg(input string name, input int exp, input int act);
		if (exp != act) begin
			reg_errors = reg_errors + 1;
			$display("mismatch %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	task automatic readback(input logic [7:0] a, input string name, input logic [7:0] d);
		write_reg(a, d);
		read_reg(a, rd);
		check_reg(name, int'(d), int'(rd));
	endtask

	// stop one cycle before the given position of the checker's model
	task automatic wait_pos(input int ly, input int h);
		do begin
			@(negedge clk_reg);
			#1;
		end while (chk_i.m_ly != ly || chk_i.m_h != h - 1);
	endtask

	task automatic wait_vblank();
		@(negedge clk_reg);
		while (!vblank_irq)
			@(negedge clk_reg);
		#5;
	endtask

	// STAT reads 1, the enables, the coincidence bit and the mode
	function automatic logic [7:0] stat_value(input int ly, input int mode);
		return {1'b1, sh_stat[6:3], 8'(ly) == sh_lyc, 2'(mode)};
	endfunction

	initial begin
		seed  = 32'h6fb;
		reset = 1'b1;
		cpu   = '0;
		repeat (4) @(posedge clk_reg);
		@(negedge clk_reg);
		reset = 1'b0;

		// ------------------------------------------------------------------------
		// register readback with the lcd off
		// ------------------------------------------------------------------------
		readback(`REG_LCDC, "lcdc readback", 8'($random(seed)) & 8'h7f);
		readback(`REG_SCY, "scy readback", 8'($random(seed)));
		readback(`REG_SCX, "scx readback", 8'($random(seed)));
		readback(`REG_BGP, "bgp readback", 8'($random(seed)));
		sh_lyc = 8'($random(seed));
		readback(`REG_LYC, "lyc readback", sh_lyc);
		sh_stat = 8'($random(seed));
		write_reg(`REG_STAT, sh_stat);
		read_reg(`REG_STAT, rd);
		check_reg("stat readback", int'(stat_value(0, 0)), int'(rd));
		// LY ignores writes
		write_reg(`REG_LY, 8'h5a);
		read_reg(`REG_LY, rd);
		check_reg("ly after write", 0, int'(rd));
		foreach (unmapped[i]) begin
			write_reg(unmapped[i], 8'h00);
			read_reg(unmapped[i], rd);
			check_reg("unmapped read", 'hff, int'(rd));
		end

		// first frame with the background disabled
		write_reg(`REG_SCX, 8'($random(seed)));
		write_reg(`REG_SCY, 8'($random(seed)));
		write_reg(`REG_BGP, 8'($random(seed)));
		sh_stat = 8'h00;
		write_reg(`REG_STAT, sh_stat);
		write_reg(`REG_LCDC, 8'h80 | (8'($random(seed)) & 8'h7e));

		// mode sequence 2, 3, 0 on a visible line
		wait_pos(1, 40);
		read_reg(`REG_STAT, rd);
		check_reg("stat mode oam", int'(stat_value(1, 2)), int'(rd));
		wait_pos(1, 150);
		read_reg(`REG_STAT, rd);
		check_reg("stat mode draw", int'(stat_value(1, 3)), int'(rd));
		wait_pos(1, 300);
		read_reg(`REG_STAT, rd);
		check_reg("stat mode hblank", int'(stat_value(1, 0)), int'(rd));
		wait_pos(5, 10);
		read_reg(`REG_LY, rd);
		check_reg("ly on line 5", 5, int'(rd));
		wait_vblank();
		wait_pos(150, 100);
		read_reg(`REG_STAT, rd);
		check_reg("stat mode vblank", int'(stat_value(150, 1)), int'(rd));
		wait_pos(150, 200);
		read_reg(`REG_LY, rd);
		check_reg("ly on line 150", 150, int'(rd));

		// ------------------------------------------------------------------------
		// one stat source per frame with random scroll and palette
		// ------------------------------------------------------------------------
		for (int f = 0; f < 4; f++) begin
			sh_lyc = 8'(int'(8'($random(seed))) % 144);
			write_reg(`REG_LYC, sh_lyc);
			write_reg(`REG_SCX, 8'($random(seed)));
			write_reg(`REG_SCY, 8'($random(seed)));
			write_reg(`REG_BGP, 8'($random(seed)));
			write_reg(`REG_LCDC, 8'h81 | (8'($random(seed)) & 8'h7e));
			sh_stat = 8'h40 >> f;
			write_reg(`REG_STAT, sh_stat);
			wait_vblank();
			check_reg($sformatf("irq count source %0d", f), exp_irqs[f], chk_i.frame_irqs);
		end

		// lcd off and the checker flags any activity
		write_reg(`REG_LCDC, 8'h00);
		sh_stat = 8'h00;
		write_reg(`REG_STAT, sh_stat);
		repeat (600) @(negedge clk_reg);
		read_reg(`REG_LY, rd);
		check_reg("ly with lcd off", 0, int'(rd));
		read_reg(`REG_STAT, rd);
		check_reg("stat with lcd off", int'(stat_value(0, 0)), int'(rd));

		$display("errors: %0d register, %0d pixel and timing mismatches, %0d other",
			reg_errors, chk_i.mismatches, chk_i.failures);
		if (reg_errors == 0 && chk_i.mismatches == 0 && chk_i.failures == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+logic
logic/video_pkg.sv
logic/lcd_timing.sv
logic/video_regs.sv
logic/bg_fetch.sv
logic/video.sv
testbench/video_checker.sv
testbench/video_tb.sv

/* run_sim.sh */
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module video_tb -o video_sim
./obj_dir/video_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
